//--- Makefile
TOOL      = verilator
FLAGS     = --timing --timescale 1ns/100ps
TOP       = ciAccelTb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_TEXT = ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/ciAccelTop.sv
`timescale 1ns/100ps

module ciAccelTop (
  input  logic          s_systemClock,
  input  logic          s_pllLocked,
  input  ciPkg::axiAddr awAddr,
  input  logic          awValid,
  output logic          awReady,
  input  ciPkg::ciWord  wData,
  input  logic [3:0]    wStrb,
  input  logic          wValid,
  output logic          wReady,
  output ciPkg::axiResp bResp,
  output logic          bValid,
  input  logic          bReady,
  input  ciPkg::axiAddr arAddr,
  input  logic          arValid,
  output logic          arReady,
  output ciPkg::ciWord  rData,
  output ciPkg::axiResp rResp,
  output logic          rValid,
  input  logic          rReady
);
  import ciPkg::*;

  logic     s_fifoFull;
  logic     s_fifoEmpty;
  logic     s_push;
  logic     s_pop;
  ciCommand s_pushCommand;
  ciCommand s_headCommand;

  ciCommandWriter writer (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .awAddr(awAddr),
    .awValid(awValid),
    .awReady(awReady),
    .wData(wData),
    .wStrb(wStrb),
    .wValid(wValid),
    .wReady(wReady),
    .bResp(bResp),
    .bValid(bValid),
    .bReady(bReady),
    .fifoFull(s_fifoFull),
    .push(s_push),
    .pushCommand(s_pushCommand)
  );

  ciCommandFifo commandFifo (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .push(s_push),
    .pushCommand(s_pushCommand),
    .pop(s_pop),
    .headCommand(s_headCommand),
    .full(s_fifoFull),
    .empty(s_fifoEmpty)
  );

  ciResultReader reader (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .arAddr(arAddr),
    .arValid(arValid),
    .arReady(arReady),
    .rData(rData),
    .rResp(rResp),
    .rValid(rValid),
    .rReady(rReady),
    .fifoEmpty(s_fifoEmpty),
    .headCommand(s_headCommand),
    .pop(s_pop)
  );

endmodule

//--- hw/ciCommandFifo.sv
`timescale 1ns/100ps

module ciCommandFifo (
  input  logic            s_systemClock,
  input  logic            s_pllLocked,
  input  logic            push,
  input  ciPkg::ciCommand pushCommand,
  input  logic            pop,
  output ciPkg::ciCommand headCommand,
  output logic            full,
  output logic            empty
);
  import ciPkg::*;

  ciCommand   s_entries [FIFO_DEPTH];
  fifoPointer s_readPointer;
  fifoPointer s_writePointer;
  fifoCount   s_count;
  logic       s_doPush;
  logic       s_doPop;

  function automatic fifoPointer nextPointer(input fifoPointer pointer);
    if (pointer == fifoPointer'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return pointer + fifoPointer'(1);
  endfunction

  assign full  = (s_count == fifoCount'(FIFO_DEPTH));
  assign empty = (s_count == '0);

  assign s_doPop  = pop & ~empty;
  assign s_doPush = push & (~full | s_doPop); // A pop frees the slot on the same edge

  assign headCommand = s_entries[s_readPointer];

  always_ff @(posedge s_systemClock) begin
    if (s_doPush) begin
      s_entries[s_writePointer] <= pushCommand;
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_readPointer  <= '0;
      s_writePointer <= '0;
      s_count        <= '0;
    end else begin
      if (s_doPush) begin
        s_writePointer <= nextPointer(s_writePointer);
      end
      if (s_doPop) begin
        s_readPointer <= nextPointer(s_readPointer);
      end
      // Occupancy
      case ({s_doPush, s_doPop})
        2'b10:   s_count <= s_count + fifoCount'(1);
        2'b01:   s_count <= s_count - fifoCount'(1);
        default: s_count <= s_count;
      endcase
    end
  end

endmodule

//--- hw/ciCommandWriter.sv
`timescale 1ns/100ps

module ciCommandWriter (
  input  logic            s_systemClock,
  input  logic            s_pllLocked,
  input  ciPkg::axiAddr   awAddr,
  input  logic            awValid,
  output logic            awReady,
  input  ciPkg::ciWord    wData,
  input  logic [3:0]      wStrb,
  input  logic            wValid,
  output logic            wReady,
  output ciPkg::axiResp   bResp,
  output logic            bValid,
  input  logic            bReady,
  input  logic            fifoFull,
  output logic            push,
  output ciPkg::ciCommand pushCommand
);
  import ciPkg::*;

  writerState s_state;
  ciWord      s_operandA;
  ciWord      s_operandB;
  logic       s_strobeFull;
  logic       s_isOperandA;
  logic       s_isOperandB;
  logic       s_isCommand;
  logic       s_blocked;
  logic       s_handshake;

  // Address and strobe decode
  assign s_strobeFull = (wStrb == 4'hF);
  assign s_isOperandA = (awAddr == REG_OPERAND_A) & s_strobeFull;
  assign s_isOperandB = (awAddr == REG_OPERAND_B) & s_strobeFull;
  assign s_isCommand  = (awAddr == REG_COMMAND) & s_strobeFull;

  // No room for another command
  assign s_blocked = (awAddr == REG_COMMAND) & fifoFull;

  assign s_handshake = (s_state == WRITE_IDLE) & awValid & wValid & ~s_blocked;
  assign awReady     = s_handshake;
  assign wReady      = s_handshake; // Both channels taken together
  assign bValid      = (s_state == WRITE_RESPOND);

  assign push        = s_handshake & s_isCommand;
  assign pushCommand = '{id: wData[7:0], valueA: s_operandA, valueB: s_operandB};

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_state <= WRITE_IDLE;
      bResp   <= RESP_OKAY;
    end else begin
      case (s_state)
        WRITE_IDLE: begin
          if (s_handshake) begin
            s_state <= WRITE_RESPOND;
            if (s_isOperandA | s_isOperandB | s_isCommand) begin
              bResp <= RESP_OKAY;
            end else begin
              bResp <= RESP_SLVERR; // Unused offset or partial strobe
            end
          end
        end
        WRITE_RESPOND: begin
          if (bReady) begin
            s_state <= WRITE_IDLE;
          end
        end
        default: s_state <= WRITE_IDLE;
      endcase
    end
  end

  // Operand registers
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_operandA <= '0;
      s_operandB <= '0;
    end else begin
      if (s_handshake & s_isOperandA) begin
        s_operandA <= wData;
      end
      if (s_handshake & s_isOperandB) begin
        s_operandB <= wData;
      end
    end
  end

endmodule

//--- hw/ciPkg.sv
package ciPkg;

  // Data path widths
  typedef logic [31:0] ciWord;
  typedef logic [7:0]  ciId;
  typedef logic [7:0]  axiAddr;
  typedef logic [1:0]  axiResp;

  localparam axiResp RESP_OKAY   = 2'b00;
  localparam axiResp RESP_SLVERR = 2'b10;

  // Register map seen by the host
  localparam axiAddr REG_OPERAND_A = 8'h00;
  localparam axiAddr REG_OPERAND_B = 8'h04;
  localparam axiAddr REG_COMMAND   = 8'h08;
  localparam axiAddr REG_RESULT    = 8'h0C;

  // Custom instruction numbers
  localparam ciId CI_SWAP_BYTE = 8'd1;
  localparam ciId CI_GRAYSCALE = 8'd12;

  localparam int FIFO_DEPTH = 4; // Commands in flight

  typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifoPointer;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifoCount;

  // One queued instruction
  typedef struct packed {
    ciId   id;
    ciWord valueA;
    ciWord valueB;
  } ciCommand;

  typedef enum logic {
    WRITE_IDLE,
    WRITE_RESPOND
  } writerState;

  typedef enum logic {
    READ_IDLE,
    READ_RESPOND
  } readerState;

endpackage

//--- hw/ciResultReader.sv
`timescale 1ns/100ps

module ciResultReader (
  input  logic            s_systemClock,
  input  logic            s_pllLocked,
  input  ciPkg::axiAddr   arAddr,
  input  logic            arValid,
  output logic            arReady,
  output ciPkg::ciWord    rData,
  output ciPkg::axiResp   rResp,
  output logic            rValid,
  input  logic            rReady,
  input  logic            fifoEmpty,
  input  ciPkg::ciCommand headCommand,
  output logic            pop
);
  import ciPkg::*;

  readerState s_state;
  ciWord      s_unitResult;
  logic       s_handshake;
  logic       s_isResult;
  logic       s_execute;

  ciUnits units (
    .command(headCommand),
    .result(s_unitResult)
  );

  assign s_handshake = (s_state == READ_IDLE) & arValid;
  assign arReady     = s_handshake;
  assign rValid      = (s_state == READ_RESPOND);

  assign s_isResult = (arAddr == REG_RESULT);
  assign s_execute  = s_handshake & s_isResult & ~fifoEmpty;

  // Head leaves the buffer on the handshake edge
  assign pop = s_execute;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_state <= READ_IDLE;
      rData   <= '0;
      rResp   <= RESP_OKAY;
    end else begin
      case (s_state)
        READ_IDLE: begin
          if (s_handshake) begin
            s_state <= READ_RESPOND;
            if (s_execute) begin
              rData <= s_unitResult;
              rResp <= RESP_OKAY;
            end else begin
              // Empty buffer or not the result register
              rData <= '0;
              rResp <= RESP_SLVERR;
            end
          end
        end
        READ_RESPOND: begin
          if (rReady) begin
            s_state <= READ_IDLE;
          end
        end
        default: s_state <= READ_IDLE;
      endcase
    end
  end

endmodule

//--- hw/ciUnits.sv
`timescale 1ns/100ps

module ciUnits (
  input  ciPkg::ciCommand command,
  output ciPkg::ciWord    result
);
  import ciPkg::*;

  ciWord       s_swapByteResult;
  ciWord       s_grayscaleResult;
  ciWord       s_swapped;
  logic [7:0]  s_red;
  logic [7:0]  s_green;
  logic [7:0]  s_blue;
  logic [15:0] s_weightedSum;

  // Byte swap unit
  always_comb begin
    if (command.valueB[0]) begin
      // Exchange within each half word
      s_swapped = {command.valueA[23:16], command.valueA[31:24],
                   command.valueA[7:0], command.valueA[15:8]};
    end else begin
      s_swapped = {command.valueA[7:0], command.valueA[15:8],
                   command.valueA[23:16], command.valueA[31:24]};
    end
  end

  assign s_swapByteResult = (command.id == CI_SWAP_BYTE) ? s_swapped : '0;

  // RGB565 fields scaled to 8 bits
  assign s_red   = {command.valueA[15:11], 3'b000};
  assign s_green = {command.valueA[10:5], 2'b00};
  assign s_blue  = {command.valueA[4:0], 3'b000};

  // Weights sum to 256
  assign s_weightedSum = 16'(s_red) * 16'd54 + 16'(s_green) * 16'd183 +
                         16'(s_blue) * 16'd19;

  assign s_grayscaleResult = (command.id == CI_GRAYSCALE) ?
                             {24'd0, s_weightedSum[15:8]} : '0;

  // Wired-OR merge so unknown ids give zero
  assign result = s_swapByteResult | s_grayscaleResult;

endmodule

//--- tests/ciAccelTb.sv
`timescale 1ns/100ps

module ciAccelTb;
  import ciPkg::*;

  localparam int LCG_SEED       = 32;
  localparam int TIMEOUT_CYCLES = 50;
  localparam int BLOCKED_CYCLES = 20;

  logic        s_systemClock;
  logic        s_pllLocked;
  axiAddr      awAddr;
  logic        awValid;
  logic        awReady;
  ciWord       wData;
  logic [3:0]  wStrb;
  logic        wValid;
  logic        wReady;
  axiResp      bResp;
  logic        bValid;
  logic        bReady;
  axiAddr      arAddr;
  logic        arValid;
  logic        arReady;
  ciWord       rData;
  axiResp      rResp;
  logic        rValid;
  logic        rReady;
  int unsigned s_lcgState = LCG_SEED;
  int          s_dataFile;

  ciClockGen clockGen (.s_systemClock(s_systemClock), .s_pllLocked(s_pllLocked));

  ciAccelTop dut (.*);

  function automatic int unsigned nextRandom();
    s_lcgState = s_lcgState * 32'd1664525 + 32'd1013904223;
    return s_lcgState >> 16;
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] got);
    if (got !== expected) begin
      abortRun($sformatf("MISMATCH time %0t signal %s expected %h got %h",
                         $time, name, expected, got));
    end
  endtask

  task automatic randomDelay();
    int cycles;
    cycles = nextRandom() % 4; // 0 to 3 idle cycles
    repeat (cycles) @(negedge s_systemClock);
  endtask

  task automatic writeTransaction(input axiAddr addr, input ciWord data,
                                  input logic [3:0] strb, input axiResp expResp);
    int count;
    @(negedge s_systemClock);
    awAddr  = addr;
    awValid = 1'b1;
    wData   = data;
    wStrb   = strb;
    wValid  = 1'b1;
    count   = 0;
    do begin
      @(posedge s_systemClock); // Value seen by the edge that takes the transfer
      count++;
      if (count > TIMEOUT_CYCLES)
        abortRun("Timed out waiting for awReady and wReady");
    end while (!(awReady && wReady));
    @(negedge s_systemClock);
    awValid = 1'b0;
    wValid  = 1'b0;
    checkValue("bValid", 32'd1, 32'(bValid)); // One cycle after the handshake
    randomDelay();
    checkValue("bValid", 32'd1, 32'(bValid));
    bReady = 1'b1;
    checkValue("bResp", 32'(expResp), 32'(bResp));
    @(negedge s_systemClock);
    bReady = 1'b0;
    checkValue("bValid", 32'd0, 32'(bValid));
  endtask

  task automatic readTransaction(input axiAddr addr, input axiResp expResp,
                                 input ciWord expData);
    int count;
    @(negedge s_systemClock);
    arAddr  = addr;
    arValid = 1'b1;
    count   = 0;
    do begin
      @(posedge s_systemClock);
      count++;
      if (count > TIMEOUT_CYCLES)
        abortRun("Timed out waiting for arReady");
    end while (!arReady);
    @(negedge s_systemClock);
    arValid = 1'b0;
    checkValue("rValid", 32'd1, 32'(rValid)); // One cycle after the handshake
    randomDelay();
    checkValue("rValid", 32'd1, 32'(rValid));
    rReady = 1'b1;
    checkValue("rResp", 32'(expResp), 32'(rResp));
    checkValue("rData", expData, rData);
    @(negedge s_systemClock);
    rReady = 1'b0;
    checkValue("rValid", 32'd0, 32'(rValid));
  endtask

  // Skips comment and blank lines
  task automatic nextEntry(output bit found, output byte kind, output axiAddr addr,
                           output ciWord data, output logic [3:0] strb,
                           output axiResp resp, output ciWord expected);
    string line;
    int    fields;
    found = 1'b0;
    while (!found && !$feof(s_dataFile)) begin
      line = "";
      void'($fgets(line, s_dataFile));
      if (line.len() > 1 && line[0] != "#") begin
        fields = $sscanf(line, "%c %h %h %h %h %h", kind, addr, data, strb, resp, expected);
        if (fields != 6)
          abortRun($sformatf("Malformed line in the data file: %s", line));
        found = 1'b1;
      end
    end
  endtask

  // Write held off by a full FIFO until the paired read frees a slot
  task automatic blockedWrite(input axiAddr addr, input ciWord data,
                              input logic [3:0] strb, input axiResp expResp);
    bit         found;
    byte        kind;
    axiAddr     readAddr;
    ciWord      unusedData;
    logic [3:0] unusedStrb;
    axiResp     readResp;
    ciWord      readData;
    nextEntry(found, kind, readAddr, unusedData, unusedStrb, readResp, readData);
    if (!found || kind != "R")
      abortRun("A blocked write line must be followed by a read line");
    fork
      writeTransaction(addr, data, strb, expResp);
      begin
        @(negedge s_systemClock);
        repeat (BLOCKED_CYCLES) begin
          @(posedge s_systemClock);
          checkValue("awReady", 32'd0, 32'(awReady)); // Expected back-pressure
          checkValue("wReady", 32'd0, 32'(wReady));
        end
        readTransaction(readAddr, readResp, readData);
      end
    join
  endtask

  initial begin
    bit         found;
    byte        kind;
    axiAddr     addr;
    ciWord      data;
    logic [3:0] strb;
    axiResp     resp;
    ciWord      expected;
    int         count;
    int         entries;
    awAddr  = '0;
    awValid = 1'b0;
    wData   = '0;
    wStrb   = '0;
    wValid  = 1'b0;
    bReady  = 1'b0;
    arAddr  = '0;
    arValid = 1'b0;
    rReady  = 1'b0;
    s_dataFile = $fopen("tests/ciAccelTests.dat", "r");
    if (s_dataFile == 0)
      abortRun("Could not open tests/ciAccelTests.dat");
    count = 0;
    while (s_pllLocked !== 1'b1) begin
      @(negedge s_systemClock);
      count++;
      if (count > TIMEOUT_CYCLES)
        abortRun("Reset was never released");
      checkValue("bValid", 32'd0, 32'(bValid));
      checkValue("rValid", 32'd0, 32'(rValid));
    end
    entries = 0;
    nextEntry(found, kind, addr, data, strb, resp, expected);
    while (found) begin
      randomDelay();
      case (kind)
        "W": writeTransaction(addr, data, strb, resp);
        "R": readTransaction(addr, resp, expected);
        "B": blockedWrite(addr, data, strb, resp);
        default: abortRun($sformatf("Unknown transaction kind %c", kind));
      endcase
      entries++;
      nextEntry(found, kind, addr, data, strb, resp, expected);
    end
    $fclose(s_dataFile);
    if (entries == 0) begin
      abortRun("The data file holds no transactions");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- tests/ciAccelTests.dat
# kind addr data strb resp expected (W write, R read, B write held off by a full FIFO)
R 0C 00000000 F 2 00000000
R 00 00000000 F 2 00000000
W 10 00000000 F 2 00000000
W 00 DEADBEEF 3 2 00000000
W 00 12345678 F 0 00000000
W 04 00000000 F 0 00000000
W 08 00000001 F 0 00000000
R 0C 00000000 F 0 78563412
W 04 00000001 F 0 00000000
W 08 00000001 F 0 00000000
R 0C 00000000 F 0 34127856
W 00 0000FFFF F 0 00000000
W 08 0000000C F 0 00000000
R 0C 00000000 F 0 000000FA
W 00 ABCD8410 F 0 00000000
W 08 0000000C F 0 00000000
R 0C 00000000 F 0 00000080
W 00 00000000 F 0 00000000
W 08 0000000C F 0 00000000
R 0C 00000000 F 0 00000000
W 00 12345678 F 0 00000000
W 04 00000000 F 0 00000000
W 08 00000001 F 0 00000000
W 08 0000000C F 0 00000000
W 08 00000005 F 0 00000000
W 08 00000001 F 0 00000000
B 08 0000000C F 0 00000000
R 0C 00000000 F 0 78563412
R 0C 00000000 F 0 000000B0
R 0C 00000000 F 0 00000000
R 0C 00000000 F 0 78563412
R 0C 00000000 F 0 000000B0

//--- tests/ciClockGen.sv
`timescale 1ns/100ps

module ciClockGen (
  output logic s_systemClock,
  output logic s_pllLocked
);
  localparam time HALF_PERIOD  = 50; // 100 ns period
  localparam int  RESET_CYCLES = 5;

  initial begin
    s_systemClock = 1'b0;
    forever #HALF_PERIOD s_systemClock = ~s_systemClock;
  end

  initial begin
    s_pllLocked = 1'b0;
    repeat (RESET_CYCLES) @(posedge s_systemClock);
    @(negedge s_systemClock);
    s_pllLocked = 1'b1; // Release away from the rising edge
  end

endmodule

//--- vlog.f
hw/ciPkg.sv
hw/ciUnits.sv
hw/ciCommandWriter.sv
hw/ciCommandFifo.sv
hw/ciResultReader.sv
hw/ciAccelTop.sv
tests/ciClockGen.sv
tests/ciAccelTb.sv
